//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= sweepAcqTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
source/sweepPkg.sv
source/modeSwitcher.sv
source/sweepSequencer.sv
source/acqFramer.sv
source/sweepAcqTop.sv
verification/sweepAcqTb.sv

//--- source/acqFramer.sv
`timescale 1ns/1ps

module acqFramer (
    input  logic                            Clk,
    input  logic                            reset,
    // Step control from the sequencer
    input  logic                            StepStart,
    input  logic [sweepPkg::DacWidth-1:0]   DacCode,
    input  logic [sweepPkg::CountWidth-1:0] MaxPackageNumber,
    // ASIC words in sweep mode
    input  logic [sweepPkg::DataWidth-1:0]  ParallelData,
    input  logic                            ParallelDataEn,
    // Framed stream
    output logic [sweepPkg::DataWidth-1:0]  SweepAcqData,
    output logic                            SweepAcqDataEn,
    output logic                            StepDone
);

    logic                                stepActive;
    logic [sweepPkg::WordCountWidth-1:0] wordCount;
    logic [sweepPkg::CountWidth-1:0]     packageCount;
    logic                                wordAccept;
    logic                                lastWord;
    logic                                lastForwarded;

    assign wordAccept = stepActive & ParallelDataEn;

    // Final word of the final package in this step
    assign lastWord = (wordCount == sweepPkg::WordCountWidth'(sweepPkg::PackageWords - 1))
                    && (packageCount == MaxPackageNumber - sweepPkg::CountWidth'(1));

    ////////////////////////////////////////////////////////////
    // Word and package counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            stepActive <= 1'b0;
            wordCount <= '0;
            packageCount <= '0;
        end else if (StepStart) begin
            // Zero packages means header only
            stepActive <= (MaxPackageNumber != '0);
            wordCount <= '0;
            packageCount <= '0;
        end else if (wordAccept) begin
            wordCount <= wordCount + 1'b1;
            if (wordCount == sweepPkg::WordCountWidth'(sweepPkg::PackageWords - 1)) begin
                packageCount <= packageCount + 1'b1;
            end
            if (lastWord) begin
                stepActive <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stream
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            SweepAcqDataEn <= 1'b0;
            lastForwarded <= 1'b0;
            StepDone <= 1'b0;
        end else begin
            SweepAcqDataEn <= StepStart | wordAccept;
            lastForwarded <= wordAccept & lastWord;
            // With no packages the step ends on the header
            StepDone <= lastForwarded | (StepStart && MaxPackageNumber == '0);
        end
    end

    always_ff @(posedge Clk) begin
        if (StepStart) begin
            SweepAcqData <= {sweepPkg::HeaderTag, DacCode};
        end else if (wordAccept) begin
            SweepAcqData <= ParallelData;
        end
    end

endmodule

//--- source/modeSwitcher.sv
`timescale 1ns/1ps

module modeSwitcher (
    input  logic                           Clk,
    input  logic                           reset,
    // Mode select from the host
    input  logic [sweepPkg::ModeWidth-1:0] ModeSelect,
    // Start and enable
    input  logic                           NormalAcqStartStop,
    input  logic                           SweepTestStart,
    input  logic                           SweepAcqStartStop,
    output logic                           SweepStart,
    output logic                           MicrorocAcqStartStop,
    // ASIC data
    input  logic [sweepPkg::DataWidth-1:0] MicrorocAcqData,
    input  logic                           MicrorocAcqDataEn,
    output logic [sweepPkg::DataWidth-1:0] ParallelData,
    output logic                           ParallelDataEn,
    // Framed sweep data
    input  logic [sweepPkg::DataWidth-1:0] SweepAcqData,
    input  logic                           SweepAcqDataEn,
    // USB FIFO write port
    output logic [sweepPkg::DataWidth-1:0] OutUsbExtFifoData,
    output logic                           OutUsbExtFifoDataEn
);

    logic sweepMode;

    ////////////////////////////////////////////////////////////
    // Mode decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ModeSelect)
            sweepPkg::ModeSweep: sweepMode = 1'b1;
            sweepPkg::ModeNormal: sweepMode = 1'b0;
            // Codes 2 and 3 act as normal mode
            default: sweepMode = 1'b0;
        endcase
    end

    // Start pulse only reaches the sequencer in sweep mode
    assign SweepStart = SweepTestStart & sweepMode;

    // ASIC acquisition enable
    assign MicrorocAcqStartStop = sweepMode ? SweepAcqStartStop : NormalAcqStartStop;

    // Raw ASIC words towards the framer
    assign ParallelData = MicrorocAcqData;
    assign ParallelDataEn = MicrorocAcqDataEn & sweepMode;

    ////////////////////////////////////////////////////////////
    // USB FIFO write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            OutUsbExtFifoDataEn <= 1'b0;
        end else if (sweepMode) begin
            OutUsbExtFifoDataEn <= SweepAcqDataEn;
        end else begin
            OutUsbExtFifoDataEn <= MicrorocAcqDataEn;
        end
    end

    // Word register follows the selected source
    always_ff @(posedge Clk) begin
        if (sweepMode) begin
            if (SweepAcqDataEn) begin
                OutUsbExtFifoData <= SweepAcqData;
            end
        end else if (MicrorocAcqDataEn) begin
            OutUsbExtFifoData <= MicrorocAcqData;
        end
    end

endmodule

//--- source/sweepAcqTop.sv
`timescale 1ns/1ps

module sweepAcqTop (
    input  logic                            Clk,
    input  logic                            reset,
    // Host control
    input  logic [sweepPkg::ModeWidth-1:0]  ModeSelect,
    input  logic                            NormalAcqStartStop,
    input  logic                            SweepTestStart,
    input  logic [sweepPkg::DacWidth-1:0]   StartDac,
    input  logic [sweepPkg::DacWidth-1:0]   EndDac,
    input  logic [sweepPkg::CountWidth-1:0] MaxPackageNumber,
    // ASIC slow control
    input  logic                            MicrorocConfigDone,
    output logic [sweepPkg::DacWidth-1:0]   OutMicroroc10BitDac0,
    output logic                            OutMicrorocScParameterLoad,
    // ASIC acquisition
    output logic                            MicrorocAcqStartStop,
    input  logic [sweepPkg::DataWidth-1:0]  MicrorocAcqData,
    input  logic                            MicrorocAcqDataEn,
    // USB FIFO
    input  logic                            UsbDataFifoFull,
    output logic [sweepPkg::DataWidth-1:0]  OutUsbExtFifoData,
    output logic                            OutUsbExtFifoDataEn,
    // Sweep completion
    input  logic                            DataTransmitDone,
    output logic                            SweepTestDone
);

    logic                           SweepStart;
    logic                           SweepAcqStartStop;
    logic                           StepStart;
    logic                           StepDone;
    logic [sweepPkg::DataWidth-1:0] ParallelData;
    logic                           ParallelDataEn;
    logic [sweepPkg::DataWidth-1:0] SweepAcqData;
    logic                           SweepAcqDataEn;

    modeSwitcher modeSwitcherInst (
        .Clk                  (Clk),
        .reset                (reset),
        .ModeSelect           (ModeSelect),
        .NormalAcqStartStop   (NormalAcqStartStop),
        .SweepTestStart       (SweepTestStart),
        .SweepAcqStartStop    (SweepAcqStartStop),
        .SweepStart           (SweepStart),
        .MicrorocAcqStartStop (MicrorocAcqStartStop),
        .MicrorocAcqData      (MicrorocAcqData),
        .MicrorocAcqDataEn    (MicrorocAcqDataEn),
        .ParallelData         (ParallelData),
        .ParallelDataEn       (ParallelDataEn),
        .SweepAcqData         (SweepAcqData),
        .SweepAcqDataEn       (SweepAcqDataEn),
        .OutUsbExtFifoData    (OutUsbExtFifoData),
        .OutUsbExtFifoDataEn  (OutUsbExtFifoDataEn)
    );

    // DAC code feeds both the ASIC and the header builder
    sweepSequencer sweepSequencerInst (
        .Clk                (Clk),
        .reset              (reset),
        .SweepStart         (SweepStart),
        .StartDac           (StartDac),
        .EndDac             (EndDac),
        .MicrorocConfigDone (MicrorocConfigDone),
        .OutDac             (OutMicroroc10BitDac0),
        .ScParameterLoad    (OutMicrorocScParameterLoad),
        .UsbDataFifoFull    (UsbDataFifoFull),
        .StepDone           (StepDone),
        .SweepAcqStartStop  (SweepAcqStartStop),
        .StepStart          (StepStart),
        .DataTransmitDone   (DataTransmitDone),
        .SweepTestDone      (SweepTestDone)
    );

    acqFramer acqFramerInst (
        .Clk              (Clk),
        .reset            (reset),
        .StepStart        (StepStart),
        .DacCode          (OutMicroroc10BitDac0),
        .MaxPackageNumber (MaxPackageNumber),
        .ParallelData     (ParallelData),
        .ParallelDataEn   (ParallelDataEn),
        .SweepAcqData     (SweepAcqData),
        .SweepAcqDataEn   (SweepAcqDataEn),
        .StepDone         (StepDone)
    );

endmodule

//--- source/sweepPkg.sv
package sweepPkg;

    ////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////

    // Threshold DAC code of the ASIC
    localparam int DacWidth = 10;
    // ASIC and USB data words
    localparam int DataWidth = 16;
    // Package count setting from the host
    localparam int CountWidth = 16;

    // Words in one ASIC data package
    localparam int PackageWords = 4;
    localparam int WordCountWidth = $clog2(PackageWords);

    ////////////////////////////////////////////////////////////
    // Mode codes and header layout
    ////////////////////////////////////////////////////////////

    localparam int ModeWidth = 2;
    localparam logic [ModeWidth-1:0] ModeNormal = 2'd0;
    localparam logic [ModeWidth-1:0] ModeSweep = 2'd1;

    // Header word is the tag on top of the DAC code
    localparam int TagWidth = DataWidth - DacWidth;
    localparam logic [TagWidth-1:0] HeaderTag = 6'b110101;

    // Sweep sequencer FSM
    typedef enum logic [2:0] {
        StateIdle,
        StateLoad,
        StateWaitConfig,
        StateAcquire,
        StateWaitTransmit,
        StateDone
    } sweepStateT;

endpackage

//--- source/sweepSequencer.sv
`timescale 1ns/1ps

module sweepSequencer (
    input  logic                          Clk,
    input  logic                          reset,
    // Sweep control
    input  logic                          SweepStart,
    input  logic [sweepPkg::DacWidth-1:0] StartDac,
    input  logic [sweepPkg::DacWidth-1:0] EndDac,
    // ASIC slow control
    input  logic                          MicrorocConfigDone,
    output logic [sweepPkg::DacWidth-1:0] OutDac,
    output logic                          ScParameterLoad,
    // Acquisition per step
    input  logic                          UsbDataFifoFull,
    input  logic                          StepDone,
    output logic                          SweepAcqStartStop,
    output logic                          StepStart,
    // End of sweep
    input  logic                          DataTransmitDone,
    output logic                          SweepTestDone
);

    sweepPkg::sweepStateT state;
    sweepPkg::sweepStateT stateNext;

    // Config done seen while the FIFO was still full
    logic configSeen;
    logic stepGo;

    // Step may start once configured and the FIFO has room
    assign stepGo = (MicrorocConfigDone | configSeen) & ~UsbDataFifoFull;

    ////////////////////////////////////////////////////////////
    // State register and next state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= sweepPkg::StateIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            sweepPkg::StateIdle: begin
                if (SweepStart) begin
                    stateNext = sweepPkg::StateLoad;
                end
            end
            sweepPkg::StateLoad: begin
                stateNext = sweepPkg::StateWaitConfig;
            end
            sweepPkg::StateWaitConfig: begin
                if (stepGo) begin
                    stateNext = sweepPkg::StateAcquire;
                end
            end
            sweepPkg::StateAcquire: begin
                if (StepDone) begin
                    if (OutDac < EndDac) begin
                        stateNext = sweepPkg::StateLoad;
                    end else begin
                        stateNext = sweepPkg::StateWaitTransmit;
                    end
                end
            end
            sweepPkg::StateWaitTransmit: begin
                if (DataTransmitDone) begin
                    stateNext = sweepPkg::StateDone;
                end
            end
            sweepPkg::StateDone: begin
                stateNext = sweepPkg::StateIdle;
            end
            default: begin
                stateNext = sweepPkg::StateIdle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // DAC code and step control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            OutDac <= '0;
        end else if (state == sweepPkg::StateIdle && SweepStart) begin
            OutDac <= StartDac;
        end else if (state == sweepPkg::StateAcquire && StepDone && OutDac < EndDac) begin
            // Step to the next code before the load
            OutDac <= OutDac + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            configSeen <= 1'b0;
            StepStart <= 1'b0;
        end else begin
            StepStart <= 1'b0;
            if (state == sweepPkg::StateWaitConfig) begin
                if (stepGo) begin
                    configSeen <= 1'b0;
                    StepStart <= 1'b1;
                end else if (MicrorocConfigDone) begin
                    // Hold off while the FIFO is full
                    configSeen <= 1'b1;
                end
            end else begin
                configSeen <= 1'b0;
            end
        end
    end

    // Outputs decoded from the state
    assign ScParameterLoad = (state == sweepPkg::StateLoad);
    assign SweepAcqStartStop = (state == sweepPkg::StateAcquire);
    assign SweepTestDone = (state == sweepPkg::StateDone);

endmodule

//--- verification/sweepAcqTb.sv
`timescale 1ns/1ps

module sweepAcqTb;

    localparam int StallCycles = 6;
    localparam int WaitLimit = 5000;

    logic                            Clk;
    logic                            reset;
    logic [sweepPkg::ModeWidth-1:0]  ModeSelect;
    logic                            NormalAcqStartStop;
    logic                            SweepTestStart;
    logic [sweepPkg::DacWidth-1:0]   StartDac;
    logic [sweepPkg::DacWidth-1:0]   EndDac;
    logic [sweepPkg::CountWidth-1:0] MaxPackageNumber;
    logic                            MicrorocConfigDone;
    logic [sweepPkg::DacWidth-1:0]   OutMicroroc10BitDac0;
    logic                            OutMicrorocScParameterLoad;
    logic                            MicrorocAcqStartStop;
    logic [sweepPkg::DataWidth-1:0]  MicrorocAcqData;
    logic                            MicrorocAcqDataEn;
    logic                            UsbDataFifoFull;
    logic [sweepPkg::DataWidth-1:0]  OutUsbExtFifoData;
    logic                            OutUsbExtFifoDataEn;
    logic                            DataTransmitDone;
    logic                            SweepTestDone;

    // Ring of expected USB words filled by the ASIC model and drained by the monitor
    logic [sweepPkg::DataWidth-1:0] expWords [4096];
    logic [11:0] expWrite = '0;
    logic [11:0] expRead = '0;
    int riseCount = 0;
    int sentCount = 0;
    int loadCount = 0;
    int doneCount = 0;
    int mismatches = 0;
    int monitorErrors = 0;
    int seqErrors = 0;
    int riseBase;
    int loadBase;
    int expSteps;
    logic stallEnable;
    logic transmitSent;
    logic timedOut;

    sweepAcqTop dut_i (.*);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    ////////////////////////////////////////////////////////////
    // ASIC and USB FIFO model
    ////////////////////////////////////////////////////////////

    initial begin : asicModel
        int configTimer;
        int strobeTimer;
        int fullTimer;
        logic loadSeen;
        logic enableNow;
        logic enablePrev;
        void'($urandom(32'hbc1da596));
        configTimer = 0;
        strobeTimer = 0;
        fullTimer = 0;
        enablePrev = 1'b0;
        MicrorocConfigDone = 1'b0;
        MicrorocAcqData = '0;
        MicrorocAcqDataEn = 1'b0;
        UsbDataFifoFull = 1'b0;
        forever begin
            @(negedge Clk);
            loadSeen = OutMicrorocScParameterLoad;
            enableNow = MicrorocAcqStartStop;
            @(posedge Clk);
            #1;
            MicrorocConfigDone = 1'b0;
            MicrorocAcqDataEn = 1'b0;
            // Configuration done three cycles after the load
            if (loadSeen) begin
                configTimer = 3;
            end
            if (configTimer > 0) begin
                configTimer--;
                if (configTimer == 0) begin
                    MicrorocConfigDone = 1'b1;
                    if (stallEnable) begin
                        fullTimer = StallCycles;
                    end
                end
            end
            UsbDataFifoFull = (fullTimer > 0);
            if (fullTimer > 0) begin
                fullTimer--;
            end
            if (enableNow && !enablePrev) begin
                strobeTimer = 1;
                sentCount = 0;
                if (ModeSelect == sweepPkg::ModeSweep) begin
                    // Header carries the code of this step
                    expWords[expWrite] = {sweepPkg::HeaderTag,
                        StartDac + sweepPkg::DacWidth'(riseCount - riseBase)};
                    expWrite++;
                end
                riseCount++;
            end else if (enableNow) begin
                strobeTimer--;
                if (strobeTimer <= 0
                    && sentCount < int'(MaxPackageNumber) * sweepPkg::PackageWords) begin
                    MicrorocAcqDataEn = 1'b1;
                    MicrorocAcqData = sweepPkg::DataWidth'($urandom);
                    expWords[expWrite] = MicrorocAcqData;
                    expWrite++;
                    sentCount++;
                    strobeTimer = 2;
                end
            end
            enablePrev = enableNow;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    always @(negedge Clk) begin
        if (!reset) begin
            if (OutUsbExtFifoDataEn) begin
                if (expRead == expWrite) begin
                    monitorErrors++;
                    $display("USB word %h arrived with no word expected", OutUsbExtFifoData);
                end else begin
                    if (OutUsbExtFifoData !== expWords[expRead]) begin
                        mismatches++;
                        $display("MISMATCH OutUsbExtFifoData: got %h expected %h",
                                 OutUsbExtFifoData, expWords[expRead]);
                    end
                    expRead++;
                end
            end
            if (OutMicrorocScParameterLoad) begin
                if (ModeSelect != sweepPkg::ModeSweep) begin
                    monitorErrors++;
                    $display("Slow control load pulse outside sweep mode");
                end else if (loadCount - loadBase >= expSteps) begin
                    monitorErrors++;
                    $display("Load pulse beyond the last step of the sweep");
                end else if (OutMicroroc10BitDac0 !==
                             StartDac + sweepPkg::DacWidth'(loadCount - loadBase)) begin
                    mismatches++;
                    $display("MISMATCH OutMicroroc10BitDac0: got %h expected %h",
                             OutMicroroc10BitDac0,
                             StartDac + sweepPkg::DacWidth'(loadCount - loadBase));
                end
                loadCount++;
            end
            if (SweepTestDone) begin
                doneCount++;
                if (!transmitSent || expRead != expWrite) begin
                    monitorErrors++;
                    $display("SweepTestDone came before transmit done or before the last words");
                end
            end
            if (ModeSelect != sweepPkg::ModeSweep
                && MicrorocAcqStartStop !== NormalAcqStartStop) begin
                mismatches++;
                $display("MISMATCH MicrorocAcqStartStop: got %h expected %h",
                         MicrorocAcqStartStop, NormalAcqStartStop);
            end
            // FIFO full must hold the step off
            if (UsbDataFifoFull && (MicrorocAcqStartStop || OutUsbExtFifoDataEn)) begin
                monitorErrors++;
                $display("Acquisition or USB write while the USB FIFO was full");
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequence tasks
    ////////////////////////////////////////////////////////////

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d monitor errors, %0d sequence errors",
                 mismatches, monitorErrors, seqErrors);
        if (mismatches + monitorErrors + seqErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic pulseStart();
        @(posedge Clk);
        #1;
        SweepTestStart = 1'b1;
        @(posedge Clk);
        #1;
        SweepTestStart = 1'b0;
    endtask

    task automatic waitLoads(input int count);
        int cycles;
        cycles = 0;
        while (!timedOut && loadCount - loadBase < count && cycles < WaitLimit) begin
            @(posedge Clk);
            cycles++;
        end
        if (cycles >= WaitLimit) begin
            seqErrors++;
            timedOut = 1'b1;
            $display("Timeout waiting for a slow control load pulse");
        end
    endtask

    task automatic waitStream(input int steps, input int target);
        int cycles;
        cycles = 0;
        while (!timedOut
               && !(riseCount - riseBase == steps && sentCount >= target && expRead == expWrite)
               && cycles < WaitLimit) begin
            @(posedge Clk);
            cycles++;
        end
        if (cycles >= WaitLimit) begin
            seqErrors++;
            timedOut = 1'b1;
            $display("Timeout waiting for the USB stream of %0d steps", steps);
        end
    endtask

    task automatic waitDone(input int doneBase);
        int cycles;
        cycles = 0;
        while (!timedOut && doneCount == doneBase && cycles < WaitLimit) begin
            @(posedge Clk);
            cycles++;
        end
        if (cycles >= WaitLimit) begin
            seqErrors++;
            timedOut = 1'b1;
            $display("Timeout waiting for SweepTestDone");
        end
    endtask

    task automatic runVector(input logic [31:0] mode, startCode, endCode, count, stall);
        int steps;
        int doneBase;
        @(posedge Clk);
        #1;
        ModeSelect = mode[1:0];
        StartDac = startCode[9:0];
        EndDac = endCode[9:0];
        MaxPackageNumber = count[15:0];
        stallEnable = stall[0];
        transmitSent = 1'b0;
        steps = (startCode > endCode) ? 1 : int'(endCode - startCode) + 1;
        expSteps = steps;
        loadBase = loadCount;
        riseBase = riseCount;
        doneBase = doneCount;
        pulseStart();
        if (mode[1:0] == sweepPkg::ModeSweep) begin
            // A second start while busy is ignored
            waitLoads(1);
            pulseStart();
            waitStream(steps, int'(count) * sweepPkg::PackageWords);
            repeat (5) @(posedge Clk);
            #1;
            transmitSent = 1'b1;
            DataTransmitDone = 1'b1;
            @(posedge Clk);
            #1;
            DataTransmitDone = 1'b0;
            waitDone(doneBase);
            repeat (5) @(posedge Clk);
            if (!timedOut
                && (doneCount - doneBase != 1 || loadCount - loadBase != steps)) begin
                seqErrors++;
                $display("Sweep from %h to %h gave %0d done pulses and %0d loads, %0d expected",
                         startCode, endCode, doneCount - doneBase, loadCount - loadBase, steps);
            end
        end else begin
            NormalAcqStartStop = 1'b1;
            waitStream(1, int'(count) * sweepPkg::PackageWords);
            @(posedge Clk);
            #1;
            NormalAcqStartStop = 1'b0;
        end
    endtask

    initial begin : mainSequence
        int fd;
        string line;
        logic [31:0] mode;
        logic [31:0] startCode;
        logic [31:0] endCode;
        logic [31:0] count;
        logic [31:0] stall;
        reset = 1'b1;
        ModeSelect = sweepPkg::ModeNormal;
        NormalAcqStartStop = 1'b0;
        SweepTestStart = 1'b0;
        StartDac = '0;
        EndDac = '0;
        MaxPackageNumber = '0;
        DataTransmitDone = 1'b0;
        stallEnable = 1'b0;
        transmitSent = 1'b0;
        timedOut = 1'b0;
        riseBase = 0;
        loadBase = 0;
        expSteps = 0;
        repeat (2) @(posedge Clk);
        #1;
        reset = 1'b0;
        @(negedge Clk);
        if (OutUsbExtFifoDataEn || OutMicrorocScParameterLoad || MicrorocAcqStartStop
            || SweepTestDone || OutMicroroc10BitDac0 != '0) begin
            seqErrors++;
            $display("Outputs were not cleared by reset");
        end
        fd = $fopen("verification/sweepTests.txt", "r");
        if (fd == 0) begin
            seqErrors++;
            $display("Cannot open verification/sweepTests.txt");
        end else begin
            while (!$feof(fd) && !timedOut) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#"
                    && $sscanf(line, "%h %h %h %h %h", mode, startCode, endCode, count, stall) == 5)
                begin
                    runVector(mode, startCode, endCode, count, stall);
                end
            end
            $fclose(fd);
        end
        finishRun();
    end

endmodule

//--- verification/sweepTests.txt
# Columns in hex: mode startDac endDac packageCount fullStall
# Mode 1 is a sweep, modes 0 and 2 run the normal path
0 000 000 3 0
1 010 013 2 0
1 3fe 3ff 0 0
1 105 100 3 0
1 020 022 1 1
2 000 000 2 0
1 000 001 4 1
